// File: verilog/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int num_ways       = 4;
    localparam int num_sets       = 16;
    localparam int words_per_line = 4;
    localparam int word_bits      = 32;
    localparam int addr_bits      = 32;

    // Derived widths
    localparam int line_bits     = words_per_line * word_bits;
    localparam int byte_off_bits = 2;
    localparam int word_sel_bits = $clog2(words_per_line);
    localparam int index_bits    = $clog2(num_sets);
    localparam int tag_bits      = addr_bits - index_bits - word_sel_bits - byte_off_bits;
    localparam int way_bits      = $clog2(num_ways);

    typedef logic [word_bits-1:0] word_t;
    // Word 0 sits in the low bits
    typedef logic [line_bits-1:0] line_t;
    typedef logic [way_bits-1:0]  way_idx_t;

    typedef struct packed {
        logic                 is_store;
        logic [addr_bits-1:0] addr;
        word_t                wdata;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
    } cpu_resp_t;

    // Refill from L2, line-aligned address
    typedef struct packed {
        logic [addr_bits-1:0] addr;
        line_t                data;
    } l2_fill_t;

    // Dirty victim going back to L2
    typedef struct packed {
        logic [addr_bits-1:0] addr;
        line_t                data;
    } l2_wb_t;

    typedef struct packed {
        logic [index_bits-1:0]    index;
        logic [tag_bits-1:0]      tag;
        logic [word_sel_bits-1:0] word_sel;
        logic                     fill_en;
        logic                     store_en;
        word_t                    wdata;
        line_t                    fill_line;
    } way_cmd_t;

    typedef struct packed {
        logic                hit;
        logic                valid;
        logic                dirty;
        logic [tag_bits-1:0] tag;
        line_t               block;
    } way_status_t;

endpackage

// File: verilog/cache_way.sv
module cache_way
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  way_cmd_t    cmd,
    output way_status_t status
);

    // Tag and data storage, one entry per set
    logic [tag_bits-1:0] tag_mem   [num_sets];
    line_t               block_mem [num_sets];

    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;

    // Combinational read of the indexed set
    assign status.valid = valid_bits[cmd.index];
    assign status.dirty = dirty_bits[cmd.index];
    assign status.tag   = tag_mem[cmd.index];
    assign status.block = block_mem[cmd.index];
    assign status.hit   = valid_bits[cmd.index] && (tag_mem[cmd.index] == cmd.tag);

    always_ff @(posedge clk) begin
        if (cmd.fill_en) begin
            tag_mem[cmd.index]   <= cmd.tag;
            block_mem[cmd.index] <= cmd.fill_line;
        end else if (cmd.store_en) begin
            // Replace only the addressed word
            block_mem[cmd.index][cmd.word_sel*word_bits +: word_bits] <= cmd.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (cmd.fill_en) begin
            valid_bits[cmd.index] <= 1'b1;
            dirty_bits[cmd.index] <= 1'b0;
        end else if (cmd.store_en) begin
            dirty_bits[cmd.index] <= 1'b1;
        end
    end

    // A fill and a store never target the same way in one cycle
    fill_store_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cmd.fill_en && cmd.store_en)
    ) else $error("cache_way: fill_en and store_en together");

endmodule

// File: verilog/lru_tracker.sv
module lru_tracker
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  touch,
    input  logic [index_bits-1:0] touch_index,
    input  way_idx_t              touch_way,
    input  logic [index_bits-1:0] query_index,
    output way_idx_t              lru_way
);

    // Age per way, 0 is the oldest
    logic [num_ways-1:0][way_bits-1:0] age [num_sets];
    logic [way_bits-1:0] touched_age;

    function automatic logic perm_ok(input logic [num_ways-1:0][way_bits-1:0] a);
        logic [num_ways-1:0] seen;
        seen = '0;
        for (int w = 0; w < num_ways; w++) begin
            seen[a[w]] = 1'b1;
        end
        return &seen;
    endfunction

    assign touched_age = age[touch_index][touch_way];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    age[s][w] <= way_bits'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_idx_t'(w) == touch_way) begin
                    age[touch_index][w] <= way_bits'(num_ways - 1);
                end else if (age[touch_index][w] > touched_age) begin
                    // Younger ways slide down one place
                    age[touch_index][w] <= age[touch_index][w] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        lru_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (age[query_index][w] == '0) begin
                lru_way = way_idx_t'(w);
            end
        end
    end

    age_perm_check: assert property (
        @(posedge clk) disable iff (!rst_n)
        touch |=> perm_ok(age[$past(touch_index)])
    ) else $error("lru_tracker: ages of a touched set are not a permutation");

endmodule

// File: verilog/access_control.sv
module access_control
    import dcache_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    input  cpu_req_t                       req,
    input  logic                           fill_valid,
    input  l2_fill_t                       fill,
    input  logic                           hit,
    input  way_idx_t                       hit_way,
    input  logic [num_ways-1:0]            valid_mask,
    input  way_idx_t                       lru_way,
    output way_cmd_t [num_ways-1:0]        cmds,
    output way_idx_t                       victim_way,
    output logic                           lookup,
    output logic                           touch,
    output way_idx_t                       touch_way,
    output logic                           busy,
    output logic                           l2_rd_valid,
    output logic [addr_bits-1:0]           l2_rd_addr
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_miss,
        st_replay
    } state_t;

    state_t   state;
    state_t   state_next;
    cpu_req_t req_q;
    logic     fill_now;

    assign busy     = (state != st_idle);
    assign lookup   = (state == st_lookup) || (state == st_replay);
    assign fill_now = (state == st_miss) && fill_valid;

    // Request is held for the whole miss
    always_ff @(posedge clk) begin
        if (req_valid && !busy) begin
            req_q <= req;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:   if (req_valid) state_next = st_lookup;
            st_lookup,
            st_replay: state_next = hit ? st_idle : st_miss;
            st_miss:   if (fill_valid) state_next = st_replay;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Lowest invalid way first, otherwise the LRU way
    always_comb begin
        victim_way = lru_way;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    assign touch     = (lookup && hit) || fill_now;
    assign touch_way = fill_now ? victim_way : hit_way;

    assign l2_rd_valid = lookup && !hit;
    assign l2_rd_addr  = {req_q.addr[addr_bits-1:byte_off_bits+word_sel_bits],
                          {(byte_off_bits + word_sel_bits){1'b0}}};

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            cmds[w].index     = req_q.addr[byte_off_bits+word_sel_bits +: index_bits];
            cmds[w].tag       = req_q.addr[addr_bits-1 -: tag_bits];
            cmds[w].word_sel  = req_q.addr[byte_off_bits +: word_sel_bits];
            cmds[w].wdata     = req_q.wdata;
            cmds[w].fill_line = fill.data;
            cmds[w].fill_en   = fill_now && (victim_way == way_idx_t'(w));
            cmds[w].store_en  = lookup && hit && req_q.is_store && (hit_way == way_idx_t'(w));
        end
    end

    // The L2 answers only the outstanding miss, with its own line
    fill_in_miss: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill_valid |-> (state == st_miss) &&
            (fill.addr[addr_bits-1:byte_off_bits+word_sel_bits] ==
             req_q.addr[addr_bits-1:byte_off_bits+word_sel_bits])
    ) else $error("access_control: unexpected fill");

    no_req_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> !busy
    ) else $error("access_control: request strobed while busy");

endmodule

// File: verilog/hit_select.sv
module hit_select
    import dcache_pkg::*;
(
    input  way_status_t [num_ways-1:0] statuses,
    input  logic [word_sel_bits-1:0]   word_sel,
    input  logic [index_bits-1:0]      index,
    input  way_idx_t                   victim_way,
    input  logic                       is_load,
    input  logic                       lookup,
    input  logic                       fill_valid,
    output logic                       hit,
    output way_idx_t                   hit_way,
    output logic [num_ways-1:0]        valid_mask,
    output logic                       resp_valid,
    output cpu_resp_t                  resp,
    output logic                       wb_valid,
    output l2_wb_t                     wb
);

    logic [num_ways-1:0] hit_vec;
    line_t               hit_block;
    way_status_t         victim;

    // One-hot mux over the hit way
    always_comb begin
        hit_way   = '0;
        hit_block = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w]    = statuses[w].hit;
            valid_mask[w] = statuses[w].valid;
            hit_block     = hit_block | ({line_bits{statuses[w].hit}} & statuses[w].block);
            if (statuses[w].hit) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit        = |hit_vec;
    assign resp.rdata = hit_block[word_sel*word_bits +: word_bits];
    assign resp_valid = lookup && hit && is_load;

    // Old contents of the way about to be refilled
    assign victim   = statuses[victim_way];
    assign wb.addr  = {victim.tag, index, {(word_sel_bits + byte_off_bits){1'b0}}};
    assign wb.data  = victim.block;
    assign wb_valid = fill_valid && victim.valid && victim.dirty;

    // A line lives in at most one way of its set
    multi_hit_check: assert final (lookup !== 1'b1 || $onehot0(hit_vec))
        else $error("hit_select: more than one way hits");

endmodule

// File: verilog/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  cpu_req_t             req,
    input  logic                 fill_valid,
    input  l2_fill_t             fill,
    output logic                 busy,
    output logic                 resp_valid,
    output cpu_resp_t            resp,
    output logic                 l2_rd_valid,
    output logic [addr_bits-1:0] l2_rd_addr,
    output logic                 wb_valid,
    output l2_wb_t               wb
);

    way_cmd_t    [num_ways-1:0] cmds;
    way_status_t [num_ways-1:0] statuses;
    logic        [num_ways-1:0] store_mask;
    logic        [num_ways-1:0] valid_mask;

    logic     hit;
    logic     lookup;
    logic     touch;
    logic     is_load;
    way_idx_t hit_way;
    way_idx_t victim_way;
    way_idx_t touch_way;
    way_idx_t lru_way;

    genvar g;
    generate
        for (g = 0; g < num_ways; g++) begin : gen_ways
            cache_way u_way (
                .clk    (clk),
                .rst_n  (rst_n),
                .cmd    (cmds[g]),
                .status (statuses[g])
            );
            assign store_mask[g] = cmds[g].store_en;
        end
    endgenerate

    // Only a store hit raises store_en, so its absence marks a load
    assign is_load = ~|store_mask;

    access_control u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .hit         (hit),
        .hit_way     (hit_way),
        .valid_mask  (valid_mask),
        .lru_way     (lru_way),
        .cmds        (cmds),
        .victim_way  (victim_way),
        .lookup      (lookup),
        .touch       (touch),
        .touch_way   (touch_way),
        .busy        (busy),
        .l2_rd_valid (l2_rd_valid),
        .l2_rd_addr  (l2_rd_addr)
    );

    hit_select u_sel (
        .statuses   (statuses),
        .word_sel   (cmds[0].word_sel),
        .index      (cmds[0].index),
        .victim_way (victim_way),
        .is_load    (is_load),
        .lookup     (lookup),
        .fill_valid (fill_valid),
        .hit        (hit),
        .hit_way    (hit_way),
        .valid_mask (valid_mask),
        .resp_valid (resp_valid),
        .resp       (resp),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

    lru_tracker u_lru (
        .clk         (clk),
        .rst_n       (rst_n),
        .touch       (touch),
        .touch_index (cmds[0].index),
        .touch_way   (touch_way),
        .query_index (cmds[0].index),
        .lru_way     (lru_way)
    );

endmodule

// File: test/dcache_tb.sv
module dcache_tb
    import dcache_pkg::*;
;

    localparam int n_table       = 14;
    localparam int n_random      = 300;
    localparam int num_ops       = n_table + n_random;
    localparam int watchdog_time = (16 + 8 + 40 * num_ops) * 8;

    typedef struct packed {
        logic                  is_store;
        logic [tag_bits-1:0]   tag;
        logic [index_bits-1:0] set;
        logic [1:0]            word;
        word_t                 wdata;
        logic                  exp_miss;
        logic                  exp_wb;
    } op_t;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    cpu_req_t             req;
    logic                 fill_valid;
    l2_fill_t             fill;
    logic                 busy;
    logic                 resp_valid;
    cpu_resp_t            resp;
    logic                 l2_rd_valid;
    logic [addr_bits-1:0] l2_rd_addr;
    logic                 wb_valid;
    l2_wb_t               wb;

    // Golden word values and L2 contents by word address
    word_t arch_mem [bit [31:0]];
    word_t l2_mem   [bit [31:0]];

    // Reference cache state
    // lru_order[s][0] is the oldest way
    logic [tag_bits-1:0] ref_tag   [num_sets][num_ways];
    logic                ref_valid [num_sets][num_ways];
    logic                ref_dirty [num_sets][num_ways];
    int                  lru_order [num_sets][num_ways];

    logic [31:0] rng;
    op_t         op_table [n_table];

    dcache_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .l2_rd_valid (l2_rd_valid),
        .l2_rd_addr  (l2_rd_addr),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Untouched memory holds a scrambled copy of its word address
    function automatic word_t init_word(input logic [31:0] wa);
        return xorshift32(wa ^ 32'h9e37_79b9);
    endfunction

    function automatic word_t arch_word(input logic [31:0] wa);
        if (arch_mem.exists(wa)) begin
            return arch_mem[wa];
        end
        return init_word(wa);
    endfunction

    function automatic word_t l2_word(input logic [31:0] wa);
        if (l2_mem.exists(wa)) begin
            return l2_mem[wa];
        end
        return init_word(wa);
    endfunction

    function automatic line_t arch_line(input logic [31:0] line_addr);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_bits +: word_bits] = arch_word((line_addr >> 2) + w);
        end
        return l;
    endfunction

    function automatic line_t l2_line(input logic [31:0] line_addr);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_bits +: word_bits] = l2_word((line_addr >> 2) + w);
        end
        return l;
    endfunction

    function automatic logic [31:0] mk_addr(input logic [tag_bits-1:0] tag,
                                            input logic [index_bits-1:0] set,
                                            input logic [1:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    function automatic int ref_find(input int set, input logic [tag_bits-1:0] tag);
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic int ref_victim(input int set);
        for (int w = 0; w < num_ways; w++) begin
            if (!ref_valid[set][w]) begin
                return w;
            end
        end
        return lru_order[set][0];
    endfunction

    // Move the way to the newest end of the order list
    function automatic void ref_touch(input int set, input int way);
        int p;
        p = 0;
        for (int i = 0; i < num_ways; i++) begin
            if (lru_order[set][i] == way) begin
                p = i;
            end
        end
        for (int i = p; i < num_ways - 1; i++) begin
            lru_order[set][i] = lru_order[set][i+1];
        end
        lru_order[set][num_ways-1] = way;
    endfunction

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic do_op(input logic is_store, input logic [31:0] addr, input word_t wdata,
                         output logic saw_miss, output logic saw_wb);
        int                  set;
        int                  way;
        int                  victim;
        int                  delay;
        logic [tag_bits-1:0] tag;
        logic [31:0]         wa;
        logic [31:0]         line_addr;
        logic [31:0]         wb_addr;
        logic                exp_wb;
        set       = addr[7:4];
        tag       = addr[31:8];
        wa        = addr >> 2;
        line_addr = {addr[31:4], 4'h0};
        saw_wb    = 1'b0;
        way       = ref_find(set, tag);

        @(negedge clk);
        req_valid    = 1'b1;
        req.is_store = is_store;
        req.addr     = addr;
        req.wdata    = wdata;

        // Lookup cycle
        @(negedge clk);
        req_valid = 1'b0;
        #2;
        check("busy", busy, 1'b1);
        check("wb_valid", wb_valid, 1'b0);
        saw_miss = l2_rd_valid;
        check("l2_rd_valid", l2_rd_valid, way < 0);
        if (way < 0) begin
            check("l2_rd_addr", l2_rd_addr, line_addr);
            check("resp_valid", resp_valid, 1'b0);
            delay = 2 + int'(next_rand() % 8);
            repeat (delay - 1) begin
                @(negedge clk);
                #2;
                check("busy", busy, 1'b1);
                check("resp_valid", resp_valid, 1'b0);
                check("l2_rd_valid", l2_rd_valid, 1'b0);
                check("wb_valid", wb_valid, 1'b0);
            end

            // Refill cycle
            @(negedge clk);
            fill_valid = 1'b1;
            fill.addr  = line_addr;
            fill.data  = l2_line(line_addr);
            #2;
            victim = ref_victim(set);
            exp_wb = ref_valid[set][victim] && ref_dirty[set][victim];
            saw_wb = wb_valid;
            check("wb_valid", wb_valid, exp_wb);
            check("resp_valid", resp_valid, 1'b0);
            if (exp_wb) begin
                wb_addr = {ref_tag[set][victim], 4'(set), 4'h0};
                check("wb.addr", wb.addr, wb_addr);
                check("wb.data", wb.data, arch_line(wb_addr));
                for (int w = 0; w < words_per_line; w++) begin
                    l2_mem[(wb_addr >> 2) + w] = wb.data[w*word_bits +: word_bits];
                end
            end
            ref_tag[set][victim]   = tag;
            ref_valid[set][victim] = 1'b1;
            ref_dirty[set][victim] = 1'b0;
            ref_touch(set, victim);
            way = victim;

            // Replay cycle
            @(negedge clk);
            fill_valid = 1'b0;
            fill       = '0;
            #2;
            check("busy", busy, 1'b1);
            check("l2_rd_valid", l2_rd_valid, 1'b0);
            check("wb_valid", wb_valid, 1'b0);
        end

        check("resp_valid", resp_valid, !is_store);
        if (!is_store) begin
            check("resp.rdata", resp.rdata, arch_word(wa));
        end else begin
            arch_mem[wa]        = wdata;
            ref_dirty[set][way] = 1'b1;
        end
        ref_touch(set, way);

        @(negedge clk);
        #2;
        check("busy", busy, 1'b0);
        check("resp_valid", resp_valid, 1'b0);
        check("l2_rd_valid", l2_rd_valid, 1'b0);
        check("wb_valid", wb_valid, 1'b0);
    endtask

    // Watchdog
    initial begin
        #(watchdog_time);
        $display("Watchdog expired before all operations completed");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    initial begin
        logic        saw_miss;
        logic        saw_wb;
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0]  set;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        fill_valid = 1'b0;
        fill       = '0;
        rng        = 32'h23b1_d86c;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                lru_order[s][w] = w;
            end
        end

        // is_store, tag, set, word, wdata, exp_miss, exp_wb
        op_table = '{
            '{1'b0, 24'h5a0001, 4'd5, 2'd0, 32'h0,         1'b1, 1'b0},
            '{1'b0, 24'h5a0001, 4'd5, 2'd2, 32'h0,         1'b0, 1'b0},
            '{1'b1, 24'h5a0001, 4'd5, 2'd1, 32'hcafe_0a11, 1'b0, 1'b0},
            '{1'b0, 24'h5a0001, 4'd5, 2'd1, 32'h0,         1'b0, 1'b0},
            '{1'b1, 24'h5a0002, 4'd5, 2'd3, 32'h0bad_f00d, 1'b1, 1'b0},
            '{1'b0, 24'h5a0002, 4'd5, 2'd3, 32'h0,         1'b0, 1'b0},
            '{1'b0, 24'h5a0003, 4'd5, 2'd0, 32'h0,         1'b1, 1'b0},
            '{1'b0, 24'h5a0004, 4'd5, 2'd0, 32'h0,         1'b1, 1'b0},
            '{1'b0, 24'h5a0005, 4'd5, 2'd0, 32'h0,         1'b1, 1'b1},
            '{1'b0, 24'h5a0003, 4'd5, 2'd1, 32'h0,         1'b0, 1'b0},
            '{1'b0, 24'h5a0001, 4'd5, 2'd1, 32'h0,         1'b1, 1'b1},
            '{1'b0, 24'h5a0006, 4'd5, 2'd2, 32'h0,         1'b1, 1'b0},
            '{1'b1, 24'h5a0007, 4'd9, 2'd2, 32'h1234_5678, 1'b1, 1'b0},
            '{1'b0, 24'h5a0007, 4'd9, 2'd2, 32'h0,         1'b0, 1'b0}
        };

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Quiet outputs while idle after reset
        repeat (3) begin
            @(negedge clk);
            #2;
            check("busy", busy, 1'b0);
            check("resp_valid", resp_valid, 1'b0);
            check("l2_rd_valid", l2_rd_valid, 1'b0);
            check("wb_valid", wb_valid, 1'b0);
        end

        foreach (op_table[i]) begin
            addr = mk_addr(op_table[i].tag, op_table[i].set, op_table[i].word);
            do_op(op_table[i].is_store, addr, op_table[i].wdata, saw_miss, saw_wb);
            check($sformatf("l2_rd_valid (op %0d)", i), saw_miss, op_table[i].exp_miss);
            check($sformatf("wb_valid (op %0d)", i), saw_wb, op_table[i].exp_wb);
        end

        // Random mix over three sets and seven tags
        for (int n = 0; n < n_random; n++) begin
            r = next_rand();
            case (r % 3)
                0:       set = 4'd2;
                1:       set = 4'd7;
                default: set = 4'd12;
            endcase
            addr = mk_addr(24'h3c0000 | 24'(next_rand() % 7), set, r[5:4]);
            do_op(r[8], addr, next_rand(), saw_miss, saw_wb);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: verilog.f
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/lru_tracker.sv
verilog/access_control.sv
verilog/hit_select.sv
verilog/dcache_top.sv
test/dcache_tb.sv
